// File: common/snake_cfg.svh
// grid size, segment count and tick timing for the snake core; include wherever these numbers are needed
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// one coordinate, so the playfield wraps at 64 cells
`define SNAKE_COORD_W 6

// body length, slots form a ring
`define SNAKE_SEGS 4

// row used by the layout shown before a game starts
`define SNAKE_IDLE_ROW 48

// row used by the layout loaded on START
`define SNAKE_START_ROW 23

// steps a fresh direction runs before the next turn or pause
`define SNAKE_MIN_RUN 3

// main_clk cycles per game step out of reset
`define SNAKE_TICK_DEFAULT 32'd10_000_000

`endif

// File: common/snake_game_pkg.sv
// game state, direction and keyboard opcode types shared by the snake control logic and its testbench
`default_nettype none

package snake_game_pkg;

    typedef enum logic [2:0] {
        ST_IDLE  = 3'd0, // idle layout shown, waiting for START
        ST_INIT  = 3'd1,
        ST_BLANK = 3'd2, // screen off after ESC
        ST_RUN   = 3'd3,
        ST_PAUSE = 3'd4
    } game_state_e;

    typedef enum logic [1:0] {
        DIR_UP    = 2'd0,
        DIR_DOWN  = 2'd1,
        DIR_LEFT  = 2'd2,
        DIR_RIGHT = 2'd3
    } dir_e;

    // keyboard scan codes
    typedef enum logic [7:0] {
        KEY_START  = 8'h1B,
        KEY_ESC    = 8'h76,
        KEY_PAUSE  = 8'h4D,
        KEY_RESUME = 8'h2D,
        KEY_UP     = 8'h75,
        KEY_DOWN   = 8'h72,
        KEY_RIGHT  = 8'h74,
        KEY_LEFT   = 8'h6B
    } key_cmd_e;

endpackage

`default_nettype wire

// File: common/snake_apb_pkg.sv
// APB register map of the snake core, addresses and status bit positions for RTL and testbench
`default_nettype none

package snake_apb_pkg;

    typedef enum logic [7:0] {
        REG_TICK_PERIOD = 8'h00, // rw, clocks per game step
        REG_STATUS      = 8'h04  // ro
    } reg_addr_e;

    // status word layout
    localparam int STAT_STATE_LSB = 0;
    localparam int STAT_STATE_MSB = 2;
    localparam int STAT_DIR_LSB   = 4;
    localparam int STAT_DIR_MSB   = 5;
    localparam int STAT_BLANK_BIT = 8;

endpackage

`default_nettype wire

// File: source/game_tick_gen.sv
// game step enable, one main_clk cycle high every tick_period clocks, restarts when the period changes
`timescale 1ns/1ps
`default_nettype none

module game_tick_gen (
    input  wire         main_clk,
    input  wire         rst_n,
    input  wire  [31:0] tick_period,
    output logic        tick
);

    logic [31:0] count;
    logic [31:0] period_q; // period the running count was loaded from
    logic        period_chg;

    assign period_chg = (tick_period != period_q);

    // periods of 0 and 1 both tick every cycle
    assign tick = (count <= 32'd1) && !period_chg;

    always_ff @(posedge main_clk) begin
        if (!rst_n) begin
            count    <= tick_period;
            period_q <= tick_period;
        end else if (period_chg || tick) begin
            count    <= tick_period; // reload
            period_q <= tick_period;
        end else begin
            count <= count - 32'd1;
        end
    end

endmodule

`default_nettype wire

// File: snake_core/snake_control_fsm.sv
// game FSM of the snake core, holds the last key and moves state and direction on each game tick
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_control_fsm (
    input  wire                         main_clk,
    input  wire                         rst_n,
    input  wire                         tick,
    input  wire  [7:0]                  key_code,
    input  wire                         key_valid,
    output snake_game_pkg::game_state_e state,
    output snake_game_pkg::dir_e        dir,
    output logic                        blank,
    output logic                        step,
    output logic                        load_idle,
    output logic                        load_start
);

    localparam int RUN_W = $clog2(`SNAKE_MIN_RUN + 1);
    localparam logic [RUN_W-1:0] RUN_FULL = RUN_W'(`SNAKE_MIN_RUN);

    snake_game_pkg::key_cmd_e    cmd_q;
    snake_game_pkg::game_state_e state_next;
    snake_game_pkg::dir_e        dir_next;
    logic                        cmd_pend;
    logic                        key_ok;
    logic                        blank_next;
    logic                        vertical;
    logic [RUN_W-1:0]            run_cnt;
    logic [RUN_W-1:0]            run_next;

    function automatic logic known_key(input logic [7:0] code);
        case (code)
            snake_game_pkg::KEY_START, snake_game_pkg::KEY_ESC,
            snake_game_pkg::KEY_PAUSE, snake_game_pkg::KEY_RESUME,
            snake_game_pkg::KEY_UP, snake_game_pkg::KEY_DOWN,
            snake_game_pkg::KEY_RIGHT, snake_game_pkg::KEY_LEFT: known_key = 1'b1;
            default: known_key = 1'b0;
        endcase
    endfunction

    assign key_ok   = key_valid && known_key(key_code);
    assign vertical = (dir == snake_game_pkg::DIR_UP) || (dir == snake_game_pkg::DIR_DOWN);

    // body controls, qualified by tick in the body
    assign step       = (state == snake_game_pkg::ST_RUN);
    assign load_idle  = (state == snake_game_pkg::ST_IDLE);
    assign load_start = (state == snake_game_pkg::ST_INIT);

    always_comb begin
        state_next = state;
        dir_next   = dir;
        run_next   = run_cnt;
        blank_next = blank;
        if (cmd_pend && cmd_q == snake_game_pkg::KEY_ESC) begin
            state_next = snake_game_pkg::ST_BLANK;
            blank_next = 1'b1;
        end else if (cmd_pend && cmd_q == snake_game_pkg::KEY_START) begin
            state_next = snake_game_pkg::ST_INIT; // from any state
            blank_next = 1'b0;
        end else begin
            case (state)
                snake_game_pkg::ST_INIT: begin
                    state_next = snake_game_pkg::ST_RUN;
                    dir_next   = snake_game_pkg::DIR_RIGHT;
                    run_next   = RUN_FULL; // first turn allowed at once
                end
                snake_game_pkg::ST_RUN: begin
                    if (run_cnt != RUN_FULL) begin
                        run_next = run_cnt + 1'b1; // keys dropped meanwhile
                    end else if (cmd_pend) begin
                        case (cmd_q)
                            snake_game_pkg::KEY_PAUSE: state_next = snake_game_pkg::ST_PAUSE;
                            snake_game_pkg::KEY_UP: begin
                                if (!vertical) begin
                                    dir_next = snake_game_pkg::DIR_UP;
                                    run_next = '0;
                                end
                            end
                            snake_game_pkg::KEY_DOWN: begin
                                if (!vertical) begin
                                    dir_next = snake_game_pkg::DIR_DOWN;
                                    run_next = '0;
                                end
                            end
                            snake_game_pkg::KEY_LEFT: begin
                                if (vertical) begin
                                    dir_next = snake_game_pkg::DIR_LEFT;
                                    run_next = '0;
                                end
                            end
                            snake_game_pkg::KEY_RIGHT: begin
                                if (vertical) begin
                                    dir_next = snake_game_pkg::DIR_RIGHT;
                                    run_next = '0;
                                end
                            end
                            default: ;
                        endcase
                    end
                end
                snake_game_pkg::ST_PAUSE: begin
                    if (cmd_pend && cmd_q == snake_game_pkg::KEY_RESUME) begin
                        state_next = snake_game_pkg::ST_RUN; // same direction
                    end
                end
                default: ; // idle and blank wait for START or ESC
            endcase
        end
    end

    always_ff @(posedge main_clk) begin
        if (!rst_n) begin
            state    <= snake_game_pkg::ST_IDLE;
            dir      <= snake_game_pkg::DIR_RIGHT;
            run_cnt  <= '0;
            blank    <= 1'b0;
            cmd_pend <= 1'b0;
        end else begin
            if (tick) begin
                state   <= state_next;
                dir     <= dir_next;
                run_cnt <= run_next;
                blank   <= blank_next;
            end
            if (key_ok) begin
                cmd_pend <= 1'b1; // newer key wins
            end else if (tick) begin
                cmd_pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge main_clk) begin
        if (key_ok) begin
            cmd_q <= snake_game_pkg::key_cmd_e'(key_code);
        end
    end

endmodule

`default_nettype wire

// File: snake_core/snake_body.sv
// ring of snake segment coordinates, loaded with a fixed layout or stepped one cell on each game tick
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_body (
    input  wire                                            main_clk,
    input  wire                                            rst_n,
    input  wire                                            tick,
    input  wire                                            step,
    input  wire                                            load_idle,
    input  wire                                            load_start,
    input  wire snake_game_pkg::dir_e                      dir,
    output logic [`SNAKE_SEGS*`SNAKE_COORD_W-1:0]          seg_x,
    output logic [`SNAKE_SEGS*`SNAKE_COORD_W-1:0]          seg_y,
    output logic [$clog2(`SNAKE_SEGS)-1:0]                 head_slot
);

    localparam int N  = `SNAKE_SEGS;
    localparam int W  = `SNAKE_COORD_W;
    localparam int SW = $clog2(N);
    localparam logic [W-1:0] IDLE_ROW  = W'(`SNAKE_IDLE_ROW);
    localparam logic [W-1:0] START_ROW = W'(`SNAKE_START_ROW);
    localparam logic [SW-1:0] LAST     = SW'(N - 1);

    logic [W-1:0]  pos_x [N];
    logic [W-1:0]  pos_y [N];
    logic [W-1:0]  new_x;
    logic [W-1:0]  new_y;
    logic [W-1:0]  load_row;
    logic [SW-1:0] new_slot;

    // tail slot is the one after the head
    assign new_slot = (head_slot == LAST) ? '0 : head_slot + 1'b1;
    assign load_row = load_start ? START_ROW : IDLE_ROW;

    always_comb begin
        new_x = pos_x[head_slot];
        new_y = pos_y[head_slot];
        case (dir)
            snake_game_pkg::DIR_UP:    new_y = pos_y[head_slot] - 1'b1; // wraps at the edge
            snake_game_pkg::DIR_DOWN:  new_y = pos_y[head_slot] + 1'b1;
            snake_game_pkg::DIR_LEFT:  new_x = pos_x[head_slot] - 1'b1;
            default:                   new_x = pos_x[head_slot] + 1'b1;
        endcase
    end

    always_ff @(posedge main_clk) begin
        if (!rst_n) begin
            for (int i = 0; i < N; i++) begin
                pos_x[i] <= W'(i);
                pos_y[i] <= IDLE_ROW;
            end
            head_slot <= LAST;
        end else if (tick) begin
            if (load_idle || load_start) begin
                for (int i = 0; i < N; i++) begin
                    pos_x[i] <= W'(i); // horizontal line, head at the right end
                    pos_y[i] <= load_row;
                end
                head_slot <= LAST;
            end else if (step) begin
                pos_x[new_slot] <= new_x;
                pos_y[new_slot] <= new_y;
                head_slot       <= new_slot;
            end
        end
    end

    for (genvar g = 0; g < N; g++) begin : g_flat
        assign seg_x[g*W +: W] = pos_x[g]; // slot 0 in the low bits
        assign seg_y[g*W +: W] = pos_y[g];
    end

endmodule

`default_nettype wire

// File: source/snake_regs.sv
// APB register block of the snake core, sets the game tick period and reports game status
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_regs (
    input  wire                                main_clk,
    input  wire                                rst_n,
    input  wire                                psel,
    input  wire                                penable,
    input  wire                                pwrite,
    input  wire  [7:0]                         paddr,
    input  wire  [31:0]                        pwdata,
    output logic [31:0]                        prdata,
    output logic                               pready,
    output logic                               pslverr,
    input  wire snake_game_pkg::game_state_e   state,
    input  wire snake_game_pkg::dir_e          dir,
    input  wire                                blank,
    output logic [31:0]                        tick_period
);

    logic        access;
    logic        addr_tick;
    logic        addr_status;
    logic [31:0] status;

    assign access      = psel && penable;
    assign addr_tick   = (paddr == snake_apb_pkg::REG_TICK_PERIOD);
    assign addr_status = (paddr == snake_apb_pkg::REG_STATUS);

    // no wait states
    assign pready = 1'b1;

    // unknown address, or write to the read-only status
    assign pslverr = access && (!(addr_tick || addr_status) || (pwrite && addr_status));

    always_comb begin
        status = '0;
        status[snake_apb_pkg::STAT_STATE_MSB:snake_apb_pkg::STAT_STATE_LSB] = state;
        status[snake_apb_pkg::STAT_DIR_MSB:snake_apb_pkg::STAT_DIR_LSB]     = dir;
        status[snake_apb_pkg::STAT_BLANK_BIT]                               = blank;
    end

    always_comb begin
        if (addr_tick) begin
            prdata = tick_period;
        end else if (addr_status) begin
            prdata = status;
        end else begin
            prdata = '0;
        end
    end

    always_ff @(posedge main_clk) begin
        if (!rst_n) begin
            tick_period <= `SNAKE_TICK_DEFAULT;
        end else if (access && pwrite && addr_tick) begin
            tick_period <= pwdata; // lands at end of access phase
        end
    end

endmodule

`default_nettype wire

// File: source/snake_top.sv
// top of the snake control core, connects APB registers, tick generator, game FSM and body ring
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_top (
    input  wire                                    main_clk,
    input  wire                                    rst_n,
    input  wire                                    psel,
    input  wire                                    penable,
    input  wire                                    pwrite,
    input  wire  [7:0]                             paddr,
    input  wire  [31:0]                            pwdata,
    output wire  [31:0]                            prdata,
    output wire                                    pready,
    output wire                                    pslverr,
    input  wire  [7:0]                             key_code,
    input  wire                                    key_valid,
    output wire  [`SNAKE_SEGS*`SNAKE_COORD_W-1:0]  seg_x,
    output wire  [`SNAKE_SEGS*`SNAKE_COORD_W-1:0]  seg_y,
    output wire  [$clog2(`SNAKE_SEGS)-1:0]         head_slot,
    output wire                                    blank
);

    wire [31:0]                       tick_period;
    wire                              tick;
    wire snake_game_pkg::game_state_e state;
    wire snake_game_pkg::dir_e        dir;
    wire                              step;
    wire                              load_idle;
    wire                              load_start;

    snake_regs u_regs (
        .main_clk    (main_clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .state       (state),
        .dir         (dir),
        .blank       (blank),
        .tick_period (tick_period)
    );

    game_tick_gen u_tick (
        .main_clk    (main_clk),
        .rst_n       (rst_n),
        .tick_period (tick_period),
        .tick        (tick)
    );

    snake_control_fsm u_fsm (
        .main_clk   (main_clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .key_code   (key_code),
        .key_valid  (key_valid),
        .state      (state),
        .dir        (dir),
        .blank      (blank),
        .step       (step),
        .load_idle  (load_idle),
        .load_start (load_start)
    );

    // body sees the FSM outputs from before the shared tick edge
    snake_body u_body (
        .main_clk   (main_clk),
        .rst_n      (rst_n),
        .tick       (tick),
        .step       (step),
        .load_idle  (load_idle),
        .load_start (load_start),
        .dir        (dir),
        .seg_x      (seg_x),
        .seg_y      (seg_y),
        .head_slot  (head_slot)
    );

endmodule

`default_nettype wire

// File: verification/snake_checker.sv
// watches the snake core outputs and compares them with expected values on each check strobe
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_checker (
    input  wire                                   main_clk,
    input  wire                                   check_stb,
    input  wire                                   check_apb,
    input  wire                                   report,
    input  wire  [8*24-1:0]                       test_name,
    input  wire  [$clog2(`SNAKE_SEGS)-1:0]        exp_slot,
    input  wire  [`SNAKE_COORD_W-1:0]             exp_x,
    input  wire  [`SNAKE_COORD_W-1:0]             exp_y,
    input  wire                                   exp_blank,
    input  wire  [31:0]                           exp_data,
    input  wire  [31:0]                           exp_mask,
    input  wire                                   exp_err,
    input  wire  [`SNAKE_SEGS*`SNAKE_COORD_W-1:0] seg_x,
    input  wire  [`SNAKE_SEGS*`SNAKE_COORD_W-1:0] seg_y,
    input  wire  [$clog2(`SNAKE_SEGS)-1:0]        head_slot,
    input  wire                                   blank,
    input  wire  [31:0]                           prdata,
    input  wire                                   pslverr,
    output wire  [31:0]                           fail_count
);

    localparam int W = `SNAKE_COORD_W;

    int           n_pass = 0;
    int           n_fail = 0;
    logic [W-1:0] head_x;
    logic [W-1:0] head_y;

    assign head_x     = seg_x[head_slot*W +: W]; // head cell out of the ring
    assign head_y     = seg_y[head_slot*W +: W];
    assign fail_count = n_fail;

    task automatic compare_field(input string what, input logic [31:0] exp_v,
                                 input logic [31:0] act_v, inout int bad);
        if (exp_v !== act_v) begin
            $display("** Error: %0s %0s expected %0d actual %0d", test_name, what, exp_v, act_v);
            bad++;
        end
    endtask

    always @(posedge main_clk) begin
        int bad;
        bad = 0;
        if (check_stb && check_apb) begin
            compare_field("prdata", exp_data & exp_mask, prdata & exp_mask, bad); // masked fields only
            compare_field("pslverr", 32'(exp_err), 32'(pslverr), bad);
        end else if (check_stb) begin
            compare_field("head_slot", 32'(exp_slot), 32'(head_slot), bad);
            compare_field("head_x", 32'(exp_x), 32'(head_x), bad);
            compare_field("head_y", 32'(exp_y), 32'(head_y), bad);
            compare_field("blank", 32'(exp_blank), 32'(blank), bad);
        end
        if (check_stb && bad == 0) begin
            n_pass++;
            $display("ok     %0s", test_name);
        end else if (check_stb) begin
            n_fail++;
        end
        if (report) begin
            $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        end
    end

endmodule

`default_nettype wire

// File: verification/snake_tb.sv
// testbench of the snake core, programs the tick over APB and runs the key stimulus table
`timescale 1ns/1ps
`default_nettype none
`include "snake_cfg.svh"

module snake_tb;

    localparam int         SW       = $clog2(`SNAKE_SEGS);
    localparam int         XW       = `SNAKE_SEGS * `SNAKE_COORD_W;
    localparam int         CW       = `SNAKE_COORD_W;
    localparam int         NROWS    = 14;
    localparam int         TICK_CYC = 8; // game tick period written at setup
    localparam logic [7:0] NO_KEY   = 8'h00;

    logic                      main_clk;
    logic                      rst_n;
    logic                      psel, penable, pwrite;
    logic [7:0]                paddr;
    logic [31:0]               pwdata;
    wire  [31:0]               prdata;
    wire                       pready, pslverr;
    logic [7:0]                key_code;
    logic                      key_valid;
    wire  [XW-1:0]             seg_x, seg_y;
    wire  [SW-1:0]             head_slot;
    wire                       blank;
    logic                      check_stb, check_apb, report, table_ready;
    logic [8*24-1:0]           test_name;
    logic [SW-1:0]             exp_slot;
    logic [CW-1:0]             exp_x, exp_y;
    logic                      exp_blank, exp_err;
    logic [31:0]               exp_data, exp_mask;
    wire  [31:0]               fail_count;
    int                        tb_errors;

    logic [8*24-1:0]           row_name  [NROWS];
    logic [7:0]                row_key   [NROWS];
    int                        row_ticks [NROWS]; // ticks after the key took effect
    logic [SW-1:0]             row_slot  [NROWS];
    logic [CW-1:0]             row_x     [NROWS];
    logic [CW-1:0]             row_y     [NROWS];
    logic                      row_blank [NROWS];

    // all outputs a tick can change plus the status read
    wire  [2*XW+SW+32:0]       watch_vec = {seg_x, seg_y, head_slot, blank, prdata};

    snake_top dut (.*);

    snake_checker u_checker (.*);

    always #10 main_clk = ~main_clk;

    task automatic add_row(input int i, input logic [8*24-1:0] name, input logic [7:0] key,
                           input int ticks, input logic [SW-1:0] slot,
                           input logic [CW-1:0] x, input logic [CW-1:0] y, input logic blk);
        row_name[i]  = name;
        row_key[i]   = key;
        row_ticks[i] = ticks;
        row_slot[i]  = slot;
        row_x[i]     = x;
        row_y[i]     = y;
        row_blank[i] = blk;
    endtask

    task automatic fill_table();
        add_row(0,  "reset_idle",        NO_KEY,                     0, 2'd3, 6'd3,  6'd48, 1'b0);
        add_row(1,  "start_layout",      snake_game_pkg::KEY_START,  1, 2'd3, 6'd3,  6'd23, 1'b0);
        add_row(2,  "run_right",         NO_KEY,                     3, 2'd2, 6'd6,  6'd23, 1'b0);
        add_row(3,  "turn_down",         snake_game_pkg::KEY_DOWN,   3, 2'd2, 6'd7,  6'd26, 1'b0);
        add_row(4,  "turn_right",        snake_game_pkg::KEY_RIGHT,  0, 2'd3, 6'd7,  6'd27, 1'b0);
        add_row(5,  "up_early_dropped",  snake_game_pkg::KEY_UP,     1, 2'd1, 6'd9,  6'd27, 1'b0);
        add_row(6,  "run_to_min",        NO_KEY,                     1, 2'd2, 6'd10, 6'd27, 1'b0);
        add_row(7,  "turn_up",           snake_game_pkg::KEY_UP,     2, 2'd1, 6'd11, 6'd25, 1'b0);
        add_row(8,  "run_up",            NO_KEY,                     1, 2'd2, 6'd11, 6'd24, 1'b0);
        add_row(9,  "pause_freeze",      snake_game_pkg::KEY_PAUSE,  3, 2'd3, 6'd11, 6'd23, 1'b0);
        add_row(10, "resume_up",         snake_game_pkg::KEY_RESUME, 2, 2'd1, 6'd11, 6'd21, 1'b0);
        add_row(11, "esc_blank",         snake_game_pkg::KEY_ESC,    1, 2'd2, 6'd11, 6'd20, 1'b1);
        add_row(12, "restart",           snake_game_pkg::KEY_START,  1, 2'd3, 6'd3,  6'd23, 1'b0);
        add_row(13, "run_after_restart", NO_KEY,                     1, 2'd0, 6'd4,  6'd23, 1'b0);
    endtask

    task automatic apb_xfer(input logic wr, input logic [7:0] addr, input logic [31:0] data,
                            input logic chk, input logic [8*24-1:0] name,
                            input logic [31:0] edata, input logic [31:0] emask, input logic eerr);
        int waits;
        waits  = 0;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = data;
        @(negedge main_clk);
        penable = 1'b1;
        while (!pready && waits < 16) begin
            @(negedge main_clk);
            waits++;
        end
        if (!pready) begin
            $display("APB transfer to address %0h never got pready", addr);
            tb_errors++;
        end
        test_name = name;
        exp_data  = edata;
        exp_mask  = emask;
        exp_err   = eerr;
        check_apb = 1'b1;
        check_stb = chk;
        @(negedge main_clk);
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = snake_apb_pkg::REG_STATUS; // keeps status on prdata
        check_stb = 1'b0;
        check_apb = 1'b0;
    endtask

    task automatic run_row(input int r);
        logic [2*XW+SW+32:0] snap;
        int                  waited;
        snap   = watch_vec;
        waited = 0;
        if (row_key[r] != NO_KEY) begin
            key_code  = row_key[r];
            key_valid = 1'b1;
            @(negedge main_clk);
            key_valid = 1'b0;
            waited    = 1;
            // first visible change marks the tick that took the key
            while (watch_vec == snap && waited < 2 * TICK_CYC) begin
                @(negedge main_clk);
                waited++;
            end
            if (watch_vec == snap) begin
                $display("key of %0s changed no output within two tick periods", row_name[r]);
                tb_errors++;
            end
        end
        repeat (row_ticks[r] * TICK_CYC) @(negedge main_clk);
        test_name = row_name[r];
        exp_slot  = row_slot[r];
        exp_x     = row_x[r];
        exp_y     = row_y[r];
        exp_blank = row_blank[r];
        check_apb = 1'b0;
        check_stb = 1'b1;
        @(negedge main_clk);
        check_stb = 1'b0;
    endtask

    initial begin
        int r;
        main_clk    = 1'b0;
        rst_n       = 1'b0;
        psel        = 1'b0;
        penable     = 1'b0;
        pwrite      = 1'b0;
        paddr       = snake_apb_pkg::REG_STATUS;
        pwdata      = '0;
        key_code    = NO_KEY;
        key_valid   = 1'b0;
        check_stb   = 1'b0;
        check_apb   = 1'b0;
        report      = 1'b0;
        test_name   = '0;
        exp_slot    = '0;
        exp_x       = '0;
        exp_y       = '0;
        exp_blank   = 1'b0;
        exp_err     = 1'b0;
        exp_data    = '0;
        exp_mask    = '0;
        tb_errors   = 0;
        fill_table();
        table_ready = 1'b1;
        repeat (5) @(negedge main_clk);
        rst_n = 1'b1;
        apb_xfer(1'b1, snake_apb_pkg::REG_TICK_PERIOD, 32'(TICK_CYC), 1'b0, "tick_setup",
                 32'h0, 32'h0, 1'b0);
        apb_xfer(1'b0, snake_apb_pkg::REG_STATUS, 32'h0, 1'b1, "status_idle",
                 32'(snake_game_pkg::ST_IDLE) << snake_apb_pkg::STAT_STATE_LSB,
                 (32'h7 << snake_apb_pkg::STAT_STATE_LSB) |
                 (32'h1 << snake_apb_pkg::STAT_BLANK_BIT), 1'b0);
        for (r = 0; r < NROWS; r++) begin
            run_row(r);
        end
        apb_xfer(1'b1, snake_apb_pkg::REG_STATUS, 32'h1, 1'b1, "status_write_err",
                 32'h0, 32'h0, 1'b1);
        apb_xfer(1'b1, 8'h08, 32'h1, 1'b1, "unknown_addr_err", 32'h0, 32'h0, 1'b1);
        apb_xfer(1'b0, snake_apb_pkg::REG_TICK_PERIOD, 32'h0, 1'b1, "tick_readback",
                 32'(TICK_CYC), 32'hffff_ffff, 1'b0);
        report = 1'b1;
        @(negedge main_clk);
        report = 1'b0;
        if (fail_count == 0 && tb_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // run limit is twice the tick budget of the table plus a setup margin
    initial begin
        int total;
        int i;
        wait (table_ready);
        total = 0;
        for (i = 0; i < NROWS; i++) begin
            total += row_ticks[i];
        end
        repeat (total * TICK_CYC * 2 + 1000) @(posedge main_clk);
        $display("watchdog expired, the stimulus table did not finish in time");
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+common
common/snake_game_pkg.sv
common/snake_apb_pkg.sv
source/game_tick_gen.sv
snake_core/snake_control_fsm.sv
snake_core/snake_body.sv
source/snake_regs.sv
source/snake_top.sv
verification/snake_checker.sv
verification/snake_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the snake core testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module snake_tb -f all.f -Mdir obj_dir -o snake_sim \
    > build.log 2>&1 &&
./obj_dir/snake_sim > sim.log 2>&1 &&
grep -q "Test completed successfully" sim.log &&
echo "simulation passed" ||
{ echo "simulation did not pass, see build.log and sim.log"; exit 1; }
